/* source/frame_tx_pkg.sv */
package frame_tx_pkg;

    // host bus widths
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int BYTE_W   = 8;                 // MAC byte lane

    // address map, region in the top nibble
    localparam int REGION_W = 4;
    localparam int OFS_W    = ADDR_W - REGION_W;

    localparam logic [REGION_W-1:0] REGION_FRAME = 4'h7;   // frame accelerator
    localparam logic [REGION_W-1:0] REGION_RAW   = 4'h8;   // direct byte path, write only

    localparam logic [OFS_W-1:0] OFS_CTRL   = 28'h000_0000;    // frame start
    localparam logic [OFS_W-1:0] OFS_STATUS = 28'h000_0004;    // completed frame count

    // control word: [7:0] first byte, [23:16] length
    localparam int LEN_LSB  = 16;
    localparam int LEN_W    = 8;

    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [DATA_W-1:0] word_t;
    typedef logic [15:0]       count_t;          // default width of the frame counter

    typedef enum logic [1:0] {
        OP_FRAME  = 2'd0,                        // start generated frame
        OP_RAW    = 2'd1,                        // one byte as one frame
        OP_STATUS = 2'd2,                        // read frame count
        OP_BAD    = 2'd3                         // unmapped or malformed
    } op_e;

    typedef enum logic {
        FS_IDLE = 1'b0,
        FS_SEND = 1'b1
    } frame_state_e;

endpackage

/* source/op_if.sv */
`timescale 1ns/1ps

// decoded operation, one entry at a time from decode to execute
interface op_if;
    logic                  valid;
    logic                  ready;
    frame_tx_pkg::op_e     op;
    frame_tx_pkg::word_t   data;                 // host write data
    logic                  write;

    modport src (
        output valid,
        output op,
        output data,
        output write,
        input  ready
    );

    modport sink (
        input  valid,
        input  op,
        input  data,
        input  write,
        output ready
    );

endinterface

/* source/byte_stream_if.sv */
`timescale 1ns/1ps

// byte stream heading for the MAC transmit port
interface byte_stream_if;
    logic                  valid;
    logic                  ready;
    frame_tx_pkg::byte_t   data;
    logic                  start;                // first byte of frame
    logic                  last;                 // final byte of frame

    modport src (
        output valid,
        output data,
        output start,
        output last,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        input  start,
        input  last,
        output ready
    );

endinterface

/* source/cmd_decode.sv */
`timescale 1ns/1ps

module cmd_decode (
    input  logic                HCLK,
    input  logic                rst_key,
    input  logic                cmd_valid_i,
    output logic                cmd_ready_o,
    input  frame_tx_pkg::word_t cmd_addr_i,
    input  logic                cmd_write_i,
    input  frame_tx_pkg::word_t cmd_wdata_i,
    op_if.src                   op_o
);

    logic [frame_tx_pkg::REGION_W-1:0] region;
    logic [frame_tx_pkg::OFS_W-1:0]    offset;
    logic [frame_tx_pkg::LEN_W-1:0]    length;
    frame_tx_pkg::op_e                 op_next;
    logic                              cmd_fire;

    logic                              valid_q;
    frame_tx_pkg::op_e                 op_q;
    frame_tx_pkg::word_t               data_q;
    logic                              write_q;

    assign region = cmd_addr_i[frame_tx_pkg::ADDR_W-1 -: frame_tx_pkg::REGION_W];
    assign offset = cmd_addr_i[frame_tx_pkg::OFS_W-1:0];
    assign length = cmd_wdata_i[frame_tx_pkg::LEN_LSB +: frame_tx_pkg::LEN_W];

    // classify by region, offset and direction
    always_comb begin
        if (region == frame_tx_pkg::REGION_RAW && cmd_write_i) begin
            op_next = frame_tx_pkg::OP_RAW;          // any offset in the byte region
        end else if (region == frame_tx_pkg::REGION_FRAME && offset == frame_tx_pkg::OFS_CTRL
                     && cmd_write_i && length != '0) begin
            op_next = frame_tx_pkg::OP_FRAME;
        end else if (region == frame_tx_pkg::REGION_FRAME
                     && offset == frame_tx_pkg::OFS_STATUS && !cmd_write_i) begin
            op_next = frame_tx_pkg::OP_STATUS;
        end else begin
            op_next = frame_tx_pkg::OP_BAD;          // zero length lands here too
        end
    end

    // one entry, accepts while empty or draining
    assign cmd_ready_o = !valid_q || op_o.ready;
    assign cmd_fire    = cmd_valid_i && cmd_ready_o;

    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            valid_q <= 1'b0;
        end else if (cmd_ready_o) begin
            valid_q <= cmd_valid_i;
        end
    end

    always_ff @(posedge HCLK) begin
        if (cmd_fire) begin
            op_q    <= op_next;
            data_q  <= cmd_wdata_i;
            write_q <= cmd_write_i;
        end
    end

    assign op_o.valid = valid_q;
    assign op_o.op    = op_q;
    assign op_o.data  = data_q;
    assign op_o.write = write_q;

endmodule

/* source/frame_engine.sv */
`timescale 1ns/1ps

module frame_engine #(
    parameter int COUNT_W = 16
) (
    input  logic                HCLK,
    input  logic                rst_key,
    op_if.sink                  op_i,
    byte_stream_if.src          gen_o,
    byte_stream_if.src          raw_o,
    output logic                rsp_valid_o,
    input  logic                rsp_ready_i,
    output frame_tx_pkg::word_t rsp_rdata_o,
    output logic                rsp_err_o
);

    frame_tx_pkg::frame_state_e     state_q;
    frame_tx_pkg::byte_t            gen_byte_q;     // byte on offer
    logic [frame_tx_pkg::LEN_W-1:0] gen_left_q;     // bytes left, current included
    logic                           gen_first_q;
    logic                           raw_valid_q;
    frame_tx_pkg::byte_t            raw_byte_q;
    logic [COUNT_W-1:0]             frame_cnt_q;

    logic rsp_free;
    logic op_ok;
    logic op_fire;
    logic gen_last;
    logic gen_fire;
    logic raw_fire;

    // response slot free, or emptied this cycle
    assign rsp_free = !rsp_valid_o || rsp_ready_i;

    always_comb begin
        case (op_i.op)
            frame_tx_pkg::OP_FRAME: op_ok = (state_q == frame_tx_pkg::FS_IDLE);
            frame_tx_pkg::OP_RAW:   op_ok = !raw_valid_q;
            default:                op_ok = 1'b1;
        endcase
    end

    assign op_i.ready = rsp_free && op_ok;
    assign op_fire    = op_i.valid && op_i.ready;

    assign gen_last = (gen_left_q == 1);
    assign gen_fire = gen_o.valid && gen_o.ready;
    assign raw_fire = raw_o.valid && raw_o.ready;

    // frame generator, counts up from the first byte
    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            state_q     <= frame_tx_pkg::FS_IDLE;
            gen_left_q  <= '0;
            gen_first_q <= 1'b0;
        end else begin
            case (state_q)
                frame_tx_pkg::FS_IDLE: begin
                    if (op_fire && op_i.op == frame_tx_pkg::OP_FRAME) begin
                        state_q     <= frame_tx_pkg::FS_SEND;
                        gen_left_q  <= op_i.data[frame_tx_pkg::LEN_LSB +: frame_tx_pkg::LEN_W];
                        gen_first_q <= 1'b1;
                    end
                end
                frame_tx_pkg::FS_SEND: begin
                    if (gen_fire) begin
                        gen_left_q  <= gen_left_q - 1'b1;
                        gen_first_q <= 1'b0;
                        if (gen_last) begin
                            state_q <= frame_tx_pkg::FS_IDLE;
                        end
                    end
                end
                default: state_q <= frame_tx_pkg::FS_IDLE;
            endcase
        end
    end

    always_ff @(posedge HCLK) begin
        if (op_fire && op_i.op == frame_tx_pkg::OP_FRAME) begin
            gen_byte_q <= op_i.data[frame_tx_pkg::BYTE_W-1:0];
        end else if (gen_fire) begin
            gen_byte_q <= gen_byte_q + 1'b1;         // wraps at 256
        end
    end

    assign gen_o.valid = (state_q == frame_tx_pkg::FS_SEND);
    assign gen_o.data  = gen_byte_q;
    assign gen_o.start = gen_first_q;
    assign gen_o.last  = gen_last;

    // raw path, one byte frame
    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            raw_valid_q <= 1'b0;
        end else if (op_fire && op_i.op == frame_tx_pkg::OP_RAW) begin
            raw_valid_q <= 1'b1;
        end else if (raw_fire) begin
            raw_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge HCLK) begin
        if (op_fire && op_i.op == frame_tx_pkg::OP_RAW) begin
            raw_byte_q <= op_i.data[frame_tx_pkg::BYTE_W-1:0];
        end
    end

    assign raw_o.valid = raw_valid_q;
    assign raw_o.data  = raw_byte_q;
    assign raw_o.start = 1'b1;
    assign raw_o.last  = 1'b1;

    // one response per accepted operation
    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            rsp_valid_o <= 1'b0;
        end else if (op_fire) begin
            rsp_valid_o <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge HCLK) begin
        if (op_fire) begin
            if (op_i.op == frame_tx_pkg::OP_STATUS && !op_i.write) begin
                rsp_rdata_o <= frame_tx_pkg::word_t'(frame_cnt_q);
            end else begin
                rsp_rdata_o <= '0;
            end
            rsp_err_o <= (op_i.op == frame_tx_pkg::OP_BAD);
        end
    end

    // completed frames on either stream
    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            frame_cnt_q <= '0;
        end else begin
            frame_cnt_q <= frame_cnt_q + COUNT_W'(gen_fire && gen_last)
                                       + COUNT_W'(raw_fire);
        end
    end

endmodule

/* source/tx_arbiter.sv */
`timescale 1ns/1ps

module tx_arbiter (
    input  logic                HCLK,
    input  logic                rst_key,
    byte_stream_if.sink         gen_i,
    byte_stream_if.sink         raw_i,
    output frame_tx_pkg::byte_t tx_data_o,
    output logic                tx_start_o,
    output logic                tx_last_o,
    output logic                tx_valid_o,
    input  logic                tx_ready_i
);

    logic lock_q;        // generator frame in flight
    logic raw_hold_q;    // raw byte stalled on the MAC port
    logic sel_gen;
    logic gen_fire;

    // a stalled raw byte keeps the port until taken
    assign sel_gen  = !raw_hold_q && (gen_i.valid || lock_q);
    assign gen_fire = sel_gen && gen_i.valid && tx_ready_i;

    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            lock_q <= 1'b0;
        end else if (gen_fire) begin
            if (gen_i.last) begin
                lock_q <= 1'b0;
            end else if (gen_i.start) begin
                lock_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            raw_hold_q <= 1'b0;
        end else begin
            raw_hold_q <= !sel_gen && raw_i.valid && !tx_ready_i;
        end
    end

    assign tx_valid_o = sel_gen ? gen_i.valid : raw_i.valid;
    assign tx_data_o  = sel_gen ? gen_i.data  : raw_i.data;
    assign tx_start_o = sel_gen ? gen_i.start : raw_i.start;
    assign tx_last_o  = sel_gen ? gen_i.last  : raw_i.last;

    // MAC ready goes to the granted stream only
    assign gen_i.ready = sel_gen && tx_ready_i;
    assign raw_i.ready = !sel_gen && tx_ready_i;

endmodule

/* source/soc_frame_tx.sv */
`timescale 1ns/1ps

module soc_frame_tx #(
    parameter int COUNT_W = $bits(frame_tx_pkg::count_t)
) (
    input  logic                HCLK,
    input  logic                rst_key,

    // host command port
    input  logic                cmd_valid_i,
    output logic                cmd_ready_o,
    input  frame_tx_pkg::word_t cmd_addr_i,
    input  logic                cmd_write_i,
    input  frame_tx_pkg::word_t cmd_wdata_i,

    // host response port
    output logic                rsp_valid_o,
    input  logic                rsp_ready_i,
    output frame_tx_pkg::word_t rsp_rdata_o,
    output logic                rsp_err_o,

    // MAC transmit port
    output frame_tx_pkg::byte_t tx_data_o,
    output logic                tx_start_o,
    output logic                tx_last_o,
    output logic                tx_valid_o,
    input  logic                tx_ready_i
);

    op_if          op_bus ();
    byte_stream_if gen_bs ();    // generated frames
    byte_stream_if raw_bs ();    // processor bytes

    cmd_decode u_cmd_decode (
        .HCLK        (HCLK),
        .rst_key     (rst_key),
        .cmd_valid_i (cmd_valid_i),
        .cmd_ready_o (cmd_ready_o),
        .cmd_addr_i  (cmd_addr_i),
        .cmd_write_i (cmd_write_i),
        .cmd_wdata_i (cmd_wdata_i),
        .op_o        (op_bus)
    );

    frame_engine #(
        .COUNT_W     (COUNT_W)
    ) u_frame_engine (
        .HCLK        (HCLK),
        .rst_key     (rst_key),
        .op_i        (op_bus),
        .gen_o       (gen_bs),
        .raw_o       (raw_bs),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_rdata_o (rsp_rdata_o),
        .rsp_err_o   (rsp_err_o)
    );

    tx_arbiter u_tx_arbiter (
        .HCLK        (HCLK),
        .rst_key     (rst_key),
        .gen_i       (gen_bs),
        .raw_i       (raw_bs),
        .tx_data_o   (tx_data_o),
        .tx_start_o  (tx_start_o),
        .tx_last_o   (tx_last_o),
        .tx_valid_o  (tx_valid_o),
        .tx_ready_i  (tx_ready_i)
    );

endmodule

/* verification/soc_frame_tx_asserts.sv */
`timescale 1ns/1ps

module soc_frame_tx_asserts (
    input logic                HCLK,
    input logic                rst_key,
    input logic                tx_valid_o,
    input logic                tx_ready_i,
    input frame_tx_pkg::byte_t tx_data_o,
    input logic                tx_start_o,
    input logic                tx_last_o,
    input logic                rsp_valid_o,
    input logic                rsp_ready_i,
    input frame_tx_pkg::word_t rsp_rdata_o,
    input logic                rsp_err_o
);

    int   fail_cnt = 0;      // failed assertions so far
    logic in_frame_q;        // start taken, last still to come

    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            in_frame_q <= 1'b0;
        end else if (tx_valid_o && tx_ready_i) begin
            in_frame_q <= !tx_last_o;
        end
    end

    tx_hold: assert property (@(posedge HCLK) disable iff (!rst_key)
        tx_valid_o && !tx_ready_i |=> tx_valid_o
            && $stable({tx_data_o, tx_start_o, tx_last_o}))
        else begin
            fail_cnt++;
            $error("MAC payload changed while stalled");
        end

    rsp_hold: assert property (@(posedge HCLK) disable iff (!rst_key)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable({rsp_rdata_o, rsp_err_o}))
        else begin
            fail_cnt++;
            $error("response payload changed while stalled");
        end

    quiet_in_reset: assert property (@(posedge HCLK)
        !rst_key |-> !tx_valid_o && !rsp_valid_o)
        else begin
            fail_cnt++;
            $error("output valid high during reset");
        end

    // no second start until the open frame has ended
    one_frame: assert property (@(posedge HCLK) disable iff (!rst_key)
        tx_valid_o && tx_ready_i && tx_start_o |-> !in_frame_q)
        else begin
            fail_cnt++;
            $error("second frame start before last byte");
        end

endmodule

bind soc_frame_tx soc_frame_tx_asserts u_asserts (.*);

/* verification/tb_soc_frame_tx.sv */
`timescale 1ns/1ps

module tb_soc_frame_tx;

    localparam int N_CMDS    = 120;
    localparam int MAX_LEN   = 12;
    localparam int CYCLE_MAX = N_CMDS * MAX_LEN * 4 + 200;
    localparam frame_tx_pkg::word_t SEED = 32'h3f96_adce;

    logic                HCLK;
    logic                rst_key;
    logic                cmd_valid_i;
    logic                cmd_ready_o;
    frame_tx_pkg::word_t cmd_addr_i;
    logic                cmd_write_i;
    frame_tx_pkg::word_t cmd_wdata_i;
    logic                rsp_valid_o;
    logic                rsp_ready_i;
    frame_tx_pkg::word_t rsp_rdata_o;
    logic                rsp_err_o;
    frame_tx_pkg::byte_t tx_data_o;
    logic                tx_start_o;
    logic                tx_last_o;
    logic                tx_valid_o;
    logic                tx_ready_i;

    frame_tx_pkg::word_t cmd_rng;
    frame_tx_pkg::word_t rdy_rng;
    int value_errs;
    int other_errs;
    int cycles;
    int frames_issued;                       // frame and raw commands sent

    frame_tx_pkg::word_t exp_rdata[$];       // responses in command order
    logic                exp_err[$];
    frame_tx_pkg::byte_t exp_gen_first[$];   // generated frames
    int                  exp_gen_len[$];
    frame_tx_pkg::byte_t exp_raw[$];         // raw one byte frames
    frame_tx_pkg::byte_t cur_data[$];        // frame being collected

    soc_frame_tx DUT (.*);

    initial HCLK = 1'b0;
    always #4 HCLK = ~HCLK;

    function automatic frame_tx_pkg::word_t next_rand(input frame_tx_pkg::word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_word(input string name, input frame_tx_pkg::word_t got,
                              input frame_tx_pkg::word_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input frame_tx_pkg::byte_t got,
                              input frame_tx_pkg::byte_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    // called at posedge+1, returns at posedge+1 after the transfer
    task automatic send_cmd(input frame_tx_pkg::word_t addr, input logic write,
                            input frame_tx_pkg::word_t wdata);
        cmd_valid_i = 1'b1;
        cmd_addr_i  = addr;
        cmd_write_i = write;
        cmd_wdata_i = wdata;
        @(negedge HCLK);
        while (!cmd_ready_o) @(negedge HCLK);
        @(posedge HCLK);
        #1;
        cmd_valid_i = 1'b0;
    endtask

    // frame count is only stable once every expected byte is out
    task automatic read_status();
        while (exp_gen_len.size() > 0 || exp_raw.size() > 0) begin
            @(posedge HCLK);
            #1;
        end
        exp_rdata.push_back(frame_tx_pkg::word_t'(frames_issued));
        exp_err.push_back(1'b0);
        send_cmd({frame_tx_pkg::REGION_FRAME, frame_tx_pkg::OFS_STATUS}, 1'b0, '0);
    endtask

    // a one byte frame goes to the raw queue unless the generator head is identical
    task automatic match_frame();
        int n;
        int i;
        n = cur_data.size();
        if (n == 1 && exp_raw.size() > 0 && !(exp_gen_len.size() > 0
                && exp_gen_len[0] == 1 && exp_gen_first[0] == cur_data[0])) begin
            check_byte("tx_data_o", cur_data[0], exp_raw.pop_front());
        end else if (exp_gen_len.size() > 0) begin
            check_word("frame length", frame_tx_pkg::word_t'(n),
                       frame_tx_pkg::word_t'(exp_gen_len[0]));
            for (i = 0; i < n; i++) begin
                check_byte("tx_data_o", cur_data[i],
                           exp_gen_first[0] + frame_tx_pkg::byte_t'(i));
            end
            void'(exp_gen_len.pop_front());
            void'(exp_gen_first.pop_front());
        end else begin
            other_errs++;
            $display("Error: MAC frame of %0d bytes with no command behind it", n);
        end
    endtask

    // outputs sampled mid cycle, the transfer itself is at the next posedge
    always @(negedge HCLK) begin
        if (rst_key && rsp_valid_o && rsp_ready_i) begin
            if (exp_rdata.size() == 0) begin
                other_errs++;
                $display("Error: response with no command outstanding");
            end else begin
                check_word("rsp_rdata_o", rsp_rdata_o, exp_rdata.pop_front());
                check_flag("rsp_err_o", rsp_err_o, exp_err.pop_front());
            end
        end
        if (rst_key && tx_valid_o && tx_ready_i) begin
            cur_data.push_back(tx_data_o);
            check_flag("tx_start_o", tx_start_o, cur_data.size() == 1);
            if (tx_last_o) begin
                match_frame();
                cur_data.delete();
            end else if (cur_data.size() >= MAX_LEN) begin
                other_errs++;
                $display("Error: frame ran past %0d bytes without last", MAX_LEN);
                cur_data.delete();
            end
        end
    end

    always @(posedge HCLK) begin
        #1;
        rdy_rng     = next_rand(rdy_rng);
        rsp_ready_i = rdy_rng[31:16] % 16'd100 < 16'd70;     // about 70% high
        rdy_rng     = next_rand(rdy_rng);
        tx_ready_i  = rdy_rng[31:16] % 16'd100 < 16'd70;
    end

    always @(posedge HCLK) begin
        cycles++;
        if (cycles > CYCLE_MAX) begin
            $display("Error: run did not finish within %0d cycles", CYCLE_MAX);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        int k;
        int len;
        int kind;
        int assert_errs;
        frame_tx_pkg::word_t r;
        {cmd_valid_i, cmd_write_i, rsp_ready_i, tx_ready_i, rst_key} = '0;
        cmd_addr_i  = '0;
        cmd_wdata_i = '0;
        cmd_rng     = SEED;
        rdy_rng     = SEED ^ 32'h5555_5555;                  // separate ready stream
        {value_errs, other_errs, cycles, frames_issued} = '0;
        repeat (5) @(posedge HCLK);
        #1;
        rst_key = 1'b1;
        for (k = 0; k < N_CMDS; k++) begin
            cmd_rng = next_rand(cmd_rng);
            r       = cmd_rng;
            kind    = int'(r[31:24]) % 10;
            if (kind < 4) begin
                len = 1 + int'(r[23:16]) % MAX_LEN;
                exp_gen_first.push_back(r[7:0]);
                exp_gen_len.push_back(len);
                exp_rdata.push_back('0);
                exp_err.push_back(1'b0);
                frames_issued++;
                send_cmd({frame_tx_pkg::REGION_FRAME, frame_tx_pkg::OFS_CTRL}, 1'b1,
                         {8'h00, 8'(len), r[15:0]});        // bits 15:8 are noise
            end else if (kind < 7) begin
                exp_raw.push_back(r[7:0]);
                exp_rdata.push_back('0);
                exp_err.push_back(1'b0);
                frames_issued++;
                send_cmd({frame_tx_pkg::REGION_RAW, 16'h0000, r[27:16]}, 1'b1, r);
            end else if (kind < 9) begin
                exp_rdata.push_back('0);
                exp_err.push_back(1'b1);
                case (r[1:0])
                    2'd0: send_cmd({frame_tx_pkg::REGION_FRAME, frame_tx_pkg::OFS_CTRL},
                                   1'b0, r);                  // control read
                    2'd1: send_cmd({frame_tx_pkg::REGION_FRAME, frame_tx_pkg::OFS_CTRL},
                                   1'b1, {16'h0000, r[15:0]}); // zero length
                    2'd2: send_cmd({frame_tx_pkg::REGION_RAW, frame_tx_pkg::OFS_STATUS},
                                   1'b0, r);                  // raw region is write only
                    default: send_cmd({4'h3, r[27:0]}, r[8], r);
                endcase
            end else begin
                read_status();
            end
        end
        read_status();
        while (exp_rdata.size() > 0) @(posedge HCLK);
        repeat (20) @(posedge HCLK);                       // catch stray output
        if (cur_data.size() != 0) begin
            other_errs++;
            $display("Error: MAC frame left without its last byte");
        end
        assert_errs = DUT.u_asserts.fail_cnt;
        $display("Errors: %0d value, %0d other, %0d assertion",
                 value_errs, other_errs, assert_errs);
        if (value_errs + other_errs + assert_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* soc_frame_tx.f */
source/frame_tx_pkg.sv
source/op_if.sv
source/byte_stream_if.sv
source/cmd_decode.sv
source/frame_engine.sv
source/tx_arbiter.sv
source/soc_frame_tx.sv
verification/soc_frame_tx_asserts.sv
verification/tb_soc_frame_tx.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_soc_frame_tx \
    -f soc_frame_tx.f -o Vtb_soc_frame_tx || { echo "build failed"; exit 1; }

./obj_dir/Vtb_soc_frame_tx +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "Simulation finished: FAIL" sim.log && { echo "run failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "run ended early"; exit 1; }
echo "run passed"
